//--- common/fetch_macros.svh
// widths, fetch line size and thread start addresses, included by the fetch RTL and its testbench
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

////////////////////
// datapath widths
////////////////////

`define FETCH_PC_WIDTH      64 // PC and instruction memory address
`define FETCH_INST_WIDTH    32 // one instruction, two per memory line

// one memory line holds two instructions, and the PC steps by one line
`define FETCH_LINE_BYTES    8

////////////////////
// thread reset PCs
////////////////////

`define FETCH_THREAD1_START 64'h0000_0000_0000_0000
`define FETCH_THREAD2_START 64'h0000_0000_0000_1000 // thread 2 code lives above thread 1

`endif

//--- common/fetch_pkg.sv
// types shared by the fetch stage modules; pulled in by a wildcard import where needed
`include "fetch_macros.svh"

package fetch_pkg;

	////////////////////
	// port ownership
	////////////////////

	// who owns the instruction memory port this cycle
	typedef enum logic [1:0]
	{
		owner_idle,    // only the first cycle after reset in two-thread mode
		owner_thread1,
		owner_thread2
	} fetch_owner_t;

	////////////////////
	// thread controls
	////////////////////

	// back-end stall levels seen by one thread
	typedef struct packed
	{
		logic rs;     // reservation stations full
		logic rob;    // this thread's ROB full
		logic rat;    // free list empty
		logic hazard; // data access holds the memory port
	} back_stall_t;

	// branch resolution from the back end
	typedef struct packed
	{
		logic                       taken;
		logic [`FETCH_PC_WIDTH-1:0] target;
	} redirect_t;

	////////////////////
	// fetch results
	////////////////////

	typedef struct packed
	{
		logic [`FETCH_INST_WIDTH-1:0] inst1;   // low half of the line
		logic [`FETCH_INST_WIDTH-1:0] inst2;   // high half of the line
		logic                         valid1;
		logic                         valid2;
		logic [`FETCH_PC_WIDTH-1:0]   next_pc; // PC of the following line
	} inst_pair_t;

	typedef struct packed
	{
		inst_pair_t pair;
		logic       thread; // 0 for thread 1, 1 for thread 2
	} fetch_out_t;

endpackage

//--- files.f
+incdir+common
common/fetch_pkg.sv
thread_pc/thread_pc.sv
src/fetch_arbiter.sv
src/fetch_stage.sv
tb/fetch_props.sv
tb/fetch_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the fetch stage testbench with Verilator and runs it
# exit status is nonzero when the build fails or the run ends in $fatal or an assertion

cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -j 0 \
		-f files.f \
		--top-module fetch_stage_tb \
		-o fetch_stage_sim &&
	./obj_dir/fetch_stage_sim ||
	exit 1

//--- src/fetch_arbiter.sv
// owner FSM for the shared instruction memory port; steers the owner's address and pair out
`include "fetch_macros.svh"

module fetch_arbiter
	import fetch_pkg::*;
(
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       two_threads, // level, sampled at the next edge
	input  logic [`FETCH_PC_WIDTH-1:0] addr1,
	input  logic [`FETCH_PC_WIDTH-1:0] addr2,
	input  inst_pair_t                 pair1,
	input  inst_pair_t                 pair2,
	output logic                       enable1,
	output logic                       enable2,
	output logic [`FETCH_PC_WIDTH-1:0] mem_addr,
	output fetch_out_t                 fetch
);

	fetch_owner_t owner;
	fetch_owner_t owner_next;

	////////////////////
	// owner state
	////////////////////

	// two-thread mode spends one idle cycle after reset, single-thread mode starts on thread 1
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			owner <= two_threads ? owner_idle : owner_thread1;
		end
		else
		begin
			owner <= owner_next;
		end
	end

	// strict alternation, stalls never touch the rotation
	always_comb
	begin
		if (!two_threads)
		begin
			owner_next = owner_thread1; // so a switch into two-thread mode goes to thread 2 next
		end
		else
		begin
			case (owner)
				owner_idle:
				begin
					owner_next = owner_thread1;
				end
				owner_thread1:
				begin
					owner_next = owner_thread2;
				end
				owner_thread2:
				begin
					owner_next = owner_thread1;
				end
				default:
				begin
					owner_next = owner_idle;
				end
			endcase
		end
	end

	////////////////////
	// per-thread enables
	////////////////////

	assign enable1 = (owner == owner_thread1);
	assign enable2 = (owner == owner_thread2); // never both, idle drives neither

	////////////////////
	// port steering
	////////////////////

	always_comb
	begin
		case (owner)
			owner_thread1:
			begin
				mem_addr     = addr1;
				fetch.pair   = pair1;
				fetch.thread = 1'b0;
			end
			owner_thread2:
			begin
				mem_addr     = addr2;
				fetch.pair   = pair2;
				fetch.thread = 1'b1;
			end
			default:
			begin
				// idle: park the port on thread 1 and suppress the pair
				mem_addr          = addr1;
				fetch.pair        = pair1;
				fetch.pair.valid1 = 1'b0;
				fetch.pair.valid2 = 1'b0;
				fetch.thread      = 1'b0;
			end
		endcase
	end

endmodule

//--- src/fetch_stage.sv
// top of the two-thread fetch stage; connects both thread PCs to the shared memory port arbiter
`include "fetch_macros.svh"

module fetch_stage
	import fetch_pkg::*;
(
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             two_threads,
	input  redirect_t                        redirect1,
	input  redirect_t                        redirect2,
	input  back_stall_t                      thread1_stall, // only rob and hazard are taken
	input  back_stall_t                      thread2_stall, // only rob and hazard are taken
	input  logic                             rs_stall,      // shared by both threads
	input  logic                             rat_stall,     // shared by both threads
	input  logic [`FETCH_LINE_BYTES*8-1:0]   mem_data,
	input  logic                             mem_valid,
	output logic [`FETCH_PC_WIDTH-1:0]       mem_addr,
	output fetch_out_t                       fetch
);

	back_stall_t                stall1;
	back_stall_t                stall2;
	logic                       enable1;
	logic                       enable2;
	logic [`FETCH_PC_WIDTH-1:0] addr1;
	logic [`FETCH_PC_WIDTH-1:0] addr2;
	inst_pair_t                 pair1;
	inst_pair_t                 pair2;

	////////////////////
	// stall fan-out
	////////////////////

	// RS and RAT are shared structures, so they hold both threads
	assign stall1 = '{
		rs:     rs_stall,
		rob:    thread1_stall.rob,
		rat:    rat_stall,
		hazard: thread1_stall.hazard
	};
	assign stall2 = '{
		rs:     rs_stall,
		rob:    thread2_stall.rob,
		rat:    rat_stall,
		hazard: thread2_stall.hazard
	};

	////////////////////
	// thread PCs
	////////////////////

	thread_pc #(
		.START_PC   (`FETCH_THREAD1_START)
	) thread1_pc (
		.clock      (clock),
		.reset      (reset),
		.enable     (enable1),
		.redirect   (redirect1),
		.stall      (stall1),
		.mem_data   (mem_data),
		.mem_valid  (mem_valid),
		.fetch_addr (addr1),
		.pair       (pair1)
	);

	thread_pc #(
		.START_PC   (`FETCH_THREAD2_START)
	) thread2_pc (
		.clock      (clock),
		.reset      (reset),
		.enable     (enable2),
		.redirect   (redirect2),
		.stall      (stall2),
		.mem_data   (mem_data),   // both see the same line, only the owner keeps it
		.mem_valid  (mem_valid),
		.fetch_addr (addr2),
		.pair       (pair2)
	);

	////////////////////
	// port arbiter
	////////////////////

	fetch_arbiter arbiter (
		.clock       (clock),
		.reset       (reset),
		.two_threads (two_threads),
		.addr1       (addr1),
		.addr2       (addr2),
		.pair1       (pair1),
		.pair2       (pair2),
		.enable1     (enable1),
		.enable2     (enable2),
		.mem_addr    (mem_addr),
		.fetch       (fetch)
	);

endmodule

//--- tb/fetch_props.sv
// concurrent checks on the memory port arbiter, attached to every fetch_arbiter by bind
`include "fetch_macros.svh"

module fetch_props
	import fetch_pkg::*;
(
	input logic                       clock,
	input logic                       reset,
	input logic                       two_threads,
	input fetch_owner_t               owner,
	input logic                       enable1,
	input logic                       enable2,
	input logic [`FETCH_PC_WIDTH-1:0] mem_addr,
	input fetch_out_t                 fetch
);

	timeunit 1ns;
	timeprecision 100ps;

	// idle and thread 2 hand over to thread 1, thread 1 hands over to thread 2 in two-thread mode
	handover: assert property (@(posedge clock) disable iff (reset)
		((owner == owner_idle) || enable2 || (two_threads && enable1))
		|=> (enable1 != $past(enable1)) && (enable1 != enable2))
		else $error("memory port ownership did not rotate to the other thread");

	// a valid pair only comes from the thread holding the port, so never in the idle cycle
	owner_valid: assert property (@(posedge clock) disable iff (reset)
		(fetch.pair.valid1 || fetch.pair.valid2) |-> (fetch.thread ? enable2 : enable1))
		else $error("instruction pair valid without its thread owning the port");

	line_aligned: assert property (@(posedge clock) disable iff (reset) mem_addr[2:0] == 3'b000)
		else $error("memory address is not line aligned");

endmodule

bind fetch_arbiter fetch_props arbiter_props (
	.clock       (clock),
	.reset       (reset),
	.two_threads (two_threads),
	.owner       (owner),
	.enable1     (enable1),
	.enable2     (enable2),
	.mem_addr    (mem_addr),
	.fetch       (fetch)
);

//--- tb/fetch_stage_tb.sv
// self-checking testbench for the two-thread fetch stage; run with fetch_stage_tb as the top
`include "fetch_macros.svh"

module fetch_stage_tb
	import fetch_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLOCK_PERIOD    = 8;
	localparam int RESET_CYCLES    = 8;
	localparam int MEM_LINES       = 1024;
	localparam int PHASE_SINGLE    = 24;
	localparam int PHASE_DUAL      = 24;
	localparam int PHASE_STALL     = 64;
	localparam int PHASE_REDIRECT  = 64;
	localparam int PHASE_DROP      = 64;
	localparam int PHASE_SWITCH    = 32; // 8 + 12 + 4 + 8 cycles
	localparam int TOTAL_CYCLES    = 2 * RESET_CYCLES + PHASE_SINGLE + PHASE_DUAL + PHASE_STALL
	                               + PHASE_REDIRECT + PHASE_DROP + PHASE_SWITCH;
	localparam int CYCLE_LIMIT     = 2 * TOTAL_CYCLES;

	logic                           clock;
	logic                           reset;
	logic                           two_threads;
	redirect_t                      redirect1;
	redirect_t                      redirect2;
	back_stall_t                    thread1_stall;
	back_stall_t                    thread2_stall;
	logic                           rs_stall;
	logic                           rat_stall;
	logic [`FETCH_LINE_BYTES*8-1:0] mem_data;
	logic                           mem_valid;
	logic [`FETCH_PC_WIDTH-1:0]     mem_addr;
	fetch_out_t                     fetch;

	logic [`FETCH_LINE_BYTES*8-1:0] mem [MEM_LINES]; // instruction memory model
	logic [9:0]                     mem_index;

	fetch_owner_t               model_owner;
	logic [`FETCH_PC_WIDTH-1:0] model_pc1;
	logic [`FETCH_PC_WIDTH-1:0] model_pc2;

	int cycle_count     = 0;
	int checked_cycles  = 0;
	int valid_fetches1  = 0;
	int valid_fetches2  = 0;
	int idle_cycles     = 0;

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// combinational memory, wraps every 1024 lines
	assign mem_index = 10'((mem_addr / `FETCH_PC_WIDTH'(`FETCH_LINE_BYTES)) % 64'(MEM_LINES));
	assign mem_data  = mem[mem_index];

	fetch_stage fetch_stage_inst (
		.clock         (clock),
		.reset         (reset),
		.two_threads   (two_threads),
		.redirect1     (redirect1),
		.redirect2     (redirect2),
		.thread1_stall (thread1_stall),
		.thread2_stall (thread2_stall),
		.rs_stall      (rs_stall),
		.rat_stall     (rat_stall),
		.mem_data      (mem_data),
		.mem_valid     (mem_valid),
		.mem_addr      (mem_addr),
		.fetch         (fetch)
	);

	////////////////////
	// reference model
	////////////////////

	// expected outputs for this cycle, plus the owner and PCs after the next edge
	function automatic fetch_out_t predict_fetch(
		input  fetch_owner_t               owner,
		input  logic [`FETCH_PC_WIDTH-1:0] pc1,
		input  logic [`FETCH_PC_WIDTH-1:0] pc2,
		input  logic                       in_reset,
		input  logic                       mode,
		input  redirect_t                  branch1,
		input  redirect_t                  branch2,
		input  back_stall_t                stall1,
		input  back_stall_t                stall2,
		input  logic                       line_ok,
		output logic [`FETCH_PC_WIDTH-1:0] addr,
		output fetch_owner_t               owner_next,
		output logic [`FETCH_PC_WIDTH-1:0] pc1_next,
		output logic [`FETCH_PC_WIDTH-1:0] pc2_next
	);
		fetch_out_t                     result;
		logic                           ok1;
		logic                           ok2;
		logic [`FETCH_LINE_BYTES*8-1:0] line;
		logic [`FETCH_PC_WIDTH-1:0]     step;

		step = `FETCH_PC_WIDTH'(`FETCH_LINE_BYTES);
		ok1  = (owner == owner_thread1) && line_ok && (stall1 == '0) && !branch1.taken && !in_reset;
		ok2  = (owner == owner_thread2) && line_ok && (stall2 == '0) && !branch2.taken && !in_reset;
		addr = (owner == owner_thread2) ? pc2 : pc1; // idle parks on thread 1
		line = mem[10'((addr / step) % 64'(MEM_LINES))];

		result.pair.inst1   = line[`FETCH_INST_WIDTH-1:0];
		result.pair.inst2   = line[2*`FETCH_INST_WIDTH-1:`FETCH_INST_WIDTH];
		result.pair.valid1  = ok1 | ok2;
		result.pair.valid2  = ok1 | ok2;
		result.pair.next_pc = addr + step;
		result.thread       = (owner == owner_thread2);

		// ownership rotation ignores stalls
		if (in_reset)
		begin
			if (mode)
				owner_next = owner_idle;
			else
				owner_next = owner_thread1;
		end
		else if (!mode || owner != owner_thread1)
			owner_next = owner_thread1;
		else
			owner_next = owner_thread2;

		if (in_reset)
			pc1_next = `FETCH_THREAD1_START;
		else if (branch1.taken)
			pc1_next = branch1.target;
		else if (ok1)
			pc1_next = pc1 + step;
		else
			pc1_next = pc1;

		if (in_reset)
			pc2_next = `FETCH_THREAD2_START;
		else if (branch2.taken)
			pc2_next = branch2.target;
		else if (ok2)
			pc2_next = pc2 + step;
		else
			pc2_next = pc2;

		return result;
	endfunction

	task automatic check_value(
		input string                      name,
		input logic [`FETCH_PC_WIDTH-1:0] expected,
		input logic [`FETCH_PC_WIDTH-1:0] actual
	);
		if (actual !== expected)
		begin
			$display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("sim failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	////////////////////
	// compare
	////////////////////

	// inputs and outputs are settled by the falling edge
	always @(negedge clock)
	begin : compare
		fetch_out_t                 expected;
		logic [`FETCH_PC_WIDTH-1:0] expected_addr;
		fetch_owner_t               owner_next;
		logic [`FETCH_PC_WIDTH-1:0] pc1_next;
		logic [`FETCH_PC_WIDTH-1:0] pc2_next;
		back_stall_t                stall1;
		back_stall_t                stall2;

		// rs and rat hold both threads
		stall1 = '{rs: rs_stall, rob: thread1_stall.rob, rat: rat_stall,
			hazard: thread1_stall.hazard};
		stall2 = '{rs: rs_stall, rob: thread2_stall.rob, rat: rat_stall,
			hazard: thread2_stall.hazard};

		expected = predict_fetch(model_owner, model_pc1, model_pc2, reset, two_threads,
			redirect1, redirect2, stall1, stall2, mem_valid,
			expected_addr, owner_next, pc1_next, pc2_next);

		if (!reset)
		begin
			check_value("mem_addr", expected_addr, mem_addr);
			check_value("fetch.pair.inst1", 64'(expected.pair.inst1), 64'(fetch.pair.inst1));
			check_value("fetch.pair.inst2", 64'(expected.pair.inst2), 64'(fetch.pair.inst2));
			check_value("fetch.pair.valid1", 64'(expected.pair.valid1), 64'(fetch.pair.valid1));
			check_value("fetch.pair.valid2", 64'(expected.pair.valid2), 64'(fetch.pair.valid2));
			check_value("fetch.pair.next_pc", expected.pair.next_pc, fetch.pair.next_pc);
			check_value("fetch.thread", 64'(expected.thread), 64'(fetch.thread));
			checked_cycles++;
			if (model_owner == owner_idle)
				idle_cycles++;
			if (expected.pair.valid1 && !expected.thread)
				valid_fetches1++;
			if (expected.pair.valid1 && expected.thread)
				valid_fetches2++;
		end
		else
		begin
			// no pair may leave the stage while reset is high
			check_value("fetch.pair.valid1", 64'(expected.pair.valid1), 64'(fetch.pair.valid1));
			check_value("fetch.pair.valid2", 64'(expected.pair.valid2), 64'(fetch.pair.valid2));
		end

		model_owner = owner_next;
		model_pc1   = pc1_next;
		model_pc2   = pc2_next;
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("sim failed");
			$fatal(1, "timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		end
	end

	////////////////////
	// stimulus
	////////////////////

	function automatic logic chance(input int pct);
		return $urandom_range(99, 0) < pct;
	endfunction

	task automatic clear_inputs();
		redirect1     = '0;
		redirect2     = '0;
		thread1_stall = '0;
		thread2_stall = '0;
		rs_stall      = 1'b0;
		rat_stall     = 1'b0;
		mem_valid     = 1'b1;
	endtask

	task automatic drive_random(input int stall_pct, input int redirect_pct, input int drop_pct);
		redirect1.taken  = chance(redirect_pct);
		redirect1.target = {$urandom, $urandom} & ~64'h7; // line aligned
		redirect2.taken  = chance(redirect_pct);
		redirect2.target = {$urandom, $urandom} & ~64'h7;
		thread1_stall    = '0;
		thread2_stall    = '0;
		if (chance(stall_pct))
		begin
			if ($urandom_range(1, 0) != 0)
				thread1_stall.rob = 1'b1;
			else
				thread1_stall.hazard = 1'b1;
		end
		if (chance(stall_pct))
		begin
			if ($urandom_range(1, 0) != 0)
				thread2_stall.rob = 1'b1;
			else
				thread2_stall.hazard = 1'b1;
		end
		rs_stall  = chance(stall_pct / 4);
		rat_stall = chance(stall_pct / 4);
		mem_valid = !chance(drop_pct);
	endtask

	// inputs change 1 ns after each rising edge
	task automatic run_phase(input int cycles, input int stall_pct, input int redirect_pct,
		input int drop_pct);
		repeat (cycles)
		begin
			drive_random(stall_pct, redirect_pct, drop_pct);
			@(posedge clock);
			#1;
		end
	endtask

	task automatic apply_reset(input logic mode);
		reset       = 1'b1;
		two_threads = mode;
		clear_inputs();
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
	endtask

	initial
	begin
		clock = 1'b0;
		void'($urandom(32'h9b23_22ca));
		for (int i = 0; i < MEM_LINES; i++)
			mem[i] = {$urandom, $urandom};

		apply_reset(1'b0);
		run_phase(PHASE_SINGLE, 0, 0, 0);   // thread 1 alone
		apply_reset(1'b1);
		run_phase(PHASE_DUAL, 0, 0, 0);     // idle cycle, then alternation
		run_phase(PHASE_STALL, 20, 0, 0);
		run_phase(PHASE_REDIRECT, 0, 15, 0);
		run_phase(PHASE_DROP, 5, 5, 25);

		// mode switches, two-thread mode should resume on thread 2
		two_threads = 1'b0;
		run_phase(8, 10, 5, 10);
		two_threads = 1'b1;
		run_phase(12, 10, 5, 10);
		two_threads = 1'b0;
		run_phase(4, 0, 0, 0);
		two_threads = 1'b1;
		run_phase(8, 0, 0, 0);
		@(negedge clock);

		if (checked_cycles > 0 && valid_fetches1 > 0 && valid_fetches2 > 0 && idle_cycles > 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
		begin
			$display("sim failed");
			$fatal(1, "stimulus never reached a valid fetch of each thread and an idle cycle");
		end
	end

endmodule

//--- thread_pc/thread_pc.sv
// per-thread program counter that fetches one line per owned cycle; instantiate once per thread
`include "fetch_macros.svh"

module thread_pc
	import fetch_pkg::*;
#(
	parameter logic [`FETCH_PC_WIDTH-1:0] START_PC = `FETCH_THREAD1_START
)
(
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             enable,     // this thread owns the memory port
	input  redirect_t                        redirect,
	input  back_stall_t                      stall,
	input  logic [`FETCH_LINE_BYTES*8-1:0]   mem_data,   // shared line from instruction memory
	input  logic                             mem_valid,
	output logic [`FETCH_PC_WIDTH-1:0]       fetch_addr,
	output inst_pair_t                       pair
);

	logic [`FETCH_PC_WIDTH-1:0] pc;
	logic [`FETCH_PC_WIDTH-1:0] pc_plus_line;
	logic                       stalled;
	logic                       fetch_ok;

	////////////////////
	// fetch condition
	////////////////////

	// any back-end level holds the thread
	assign stalled = stall.rs | stall.rob | stall.rat | stall.hazard;

	// a taken branch kills whatever line is on the bus this cycle
	assign fetch_ok = enable
	                & mem_valid
	                & ~stalled
	                & ~redirect.taken
	                & ~reset;

	assign pc_plus_line = pc + `FETCH_PC_WIDTH'(`FETCH_LINE_BYTES);

	////////////////////
	// program counter
	////////////////////

	// redirect wins over enable and stall, otherwise advance only on a real fetch
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= START_PC;
		end
		else if (redirect.taken)
		begin
			pc <= redirect.target;
		end
		else if (fetch_ok)
		begin
			pc <= pc_plus_line;
		end
	end

	assign fetch_addr = pc; // same cycle as the line comes back

	////////////////////
	// instruction pair
	////////////////////

	// split the 64-bit line: lower word is the older instruction
	always_comb
	begin
		pair.inst1   = mem_data[`FETCH_INST_WIDTH-1:0];
		pair.inst2   = mem_data[2*`FETCH_INST_WIDTH-1:`FETCH_INST_WIDTH];
		pair.valid1  = fetch_ok;
		pair.valid2  = fetch_ok; // both halves always arrive together
		pair.next_pc = pc_plus_line;
	end

endmodule
